//--- all.f
+incdir+.
seed_pkg.sv
seed_regfile.sv
seed_fetch.sv
seed_decode.sv
seed_hazard.sv
seed_execute.sv
seed_core.sv
seed_core_props.sv
tb_seed_core.sv

//--- Bender.yml
package:
  name: seed

export_include_dirs:
  - .

sources:
  - files:
      - seed_pkg.sv
      - seed_regfile.sv
      - seed_fetch.sv
      - seed_decode.sv
      - seed_hazard.sv
      - seed_execute.sv
      - seed_core.sv
  - target: test
    files:
      - seed_core_props.sv
      - tb_seed_core.sv

//--- tb_seed_core.sv
`timescale 1ns/1ps
`include "seed_defs.svh"

module tb_seed_core;
    import seed_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk;
    logic       rst_n;
    logic       ibus_cyc, ibus_stb, ibus_we;
    addr_t      ibus_adr;
    inst_t      ibus_dat_w;
    logic [3:0] ibus_sel;
    inst_t      ibus_dat_r;
    logic       ibus_ack;
    logic       dbus_cyc, dbus_stb, dbus_we;
    addr_t      dbus_adr;
    xlen_t      dbus_dat_w;
    logic [7:0] dbus_sel;
    xlen_t      dbus_dat_r;
    logic       dbus_ack;

    integer seed = 32'h5882;
    inst_t  imem [$];           // program words starting at the reset pc
    xlen_t  dmem [256];         // doublewords at byte addresses 0x000 to 0x7ff
    xlen_t  ref_mem [256];      // the reference model's own copy of data memory
    xlen_t  ref_regs [32];
    addr_t  exp_adr [$];        // expected stores in program order
    xlen_t  exp_dat [$];
    int     stores_seen;
    int     total_stores;
    int     cycles;
    int     i_delay, d_delay;
    logic   i_busy, d_busy;

    seed_core UUT (
        .clk (clk), .rst_n (rst_n),
        .ibus_cyc (ibus_cyc), .ibus_stb (ibus_stb), .ibus_we (ibus_we),
        .ibus_adr (ibus_adr), .ibus_dat_w (ibus_dat_w), .ibus_sel (ibus_sel),
        .ibus_dat_r (ibus_dat_r), .ibus_ack (ibus_ack),
        .dbus_cyc (dbus_cyc), .dbus_stb (dbus_stb), .dbus_we (dbus_we),
        .dbus_adr (dbus_adr), .dbus_dat_w (dbus_dat_w), .dbus_sel (dbus_sel),
        .dbus_dat_r (dbus_dat_r), .dbus_ack (dbus_ack)
    );

    always #50 clk = ~clk;

    task automatic fail_banner();
        $display("Test failed");
    endtask

    task automatic show_mismatch(input string name, input xlen_t expected, input xlen_t actual);
        $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        fail_banner();
    endtask

    function automatic xlen_t fill_word(input int idx);
        return {32'hd000_0000 | idx, 32'h5eed_0000 + idx * 8}; // unique per doubleword
    endfunction

    function automatic inst_t enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                    input int rd, input logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    task automatic ref_write(input int rd, input xlen_t value);
        if (rd != 0) ref_regs[rd] = value; // x0 stays zero
    endtask

    // each task appends one instruction and steps the reference model over it
    task automatic emit_addi(input int rd, input int rs1, input int imm);
        imem.push_back(enc_i(imm, rs1, `SEED_F3_ADD, rd, `SEED_OP_IMM));
        ref_write(rd, ref_regs[rs1] + xlen_t'(longint'(imm)));
    endtask

    task automatic emit_add(input int rd, input int rs1, input int rs2);
        imem.push_back({7'd0, rs2[4:0], rs1[4:0], `SEED_F3_ADD, rd[4:0], `SEED_OP_REG});
        ref_write(rd, ref_regs[rs1] + ref_regs[rs2]);
    endtask

    task automatic emit_ld(input int rd, input int rs1, input int imm);
        xlen_t ea;
        ea = ref_regs[rs1] + xlen_t'(longint'(imm));
        imem.push_back(enc_i(imm, rs1, `SEED_F3_DWORD, rd, `SEED_OP_LOAD));
        ref_write(rd, ref_mem[ea[10:3]]);
    endtask

    task automatic emit_sd(input int rs2, input int rs1, input int imm);
        xlen_t ea;
        ea = ref_regs[rs1] + xlen_t'(longint'(imm));
        imem.push_back({imm[11:5], rs2[4:0], rs1[4:0], `SEED_F3_DWORD, imm[4:0],
                        `SEED_OP_STORE});
        exp_adr.push_back(ea[31:0]);
        exp_dat.push_back(ref_regs[rs2]);
        ref_mem[ea[10:3]] = ref_regs[rs2];
    endtask

    function automatic inst_t fetch_word(input addr_t adr);
        addr_t idx;
        idx = (adr - `SEED_RESET_PC) >> 2;
        if (adr >= `SEED_RESET_PC && idx < imem.size()) return imem[idx];
        return enc_i(0, 0, `SEED_F3_ADD, 0, `SEED_OP_IMM); // addi x0 past the program
    endfunction

    // instruction memory that acks after 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        if (ibus_ack) begin
            ibus_ack = 1'b0;
            i_busy   = 1'b0;
        end else if (rst_n && ibus_cyc && ibus_stb) begin
            if (!i_busy) begin
                i_busy  = 1'b1;
                i_delay = $unsigned($random(seed)) % 4;
            end
            if (i_delay == 0) begin
                assert (ibus_we == 1'b0) else begin
                    show_mismatch("fetch write enable", xlen_t'(1'b0), xlen_t'(ibus_we));
                    $fatal(1);
                end
                assert (ibus_sel == 4'hf) else begin
                    show_mismatch("fetch byte select", xlen_t'(4'hf), xlen_t'(ibus_sel));
                    $fatal(1);
                end
                ibus_dat_r = fetch_word(ibus_adr);
                ibus_ack   = 1'b1;
            end else begin
                i_delay = i_delay - 1;
            end
        end
    end

    // data memory with the same random wait
    always @(posedge clk) begin
        #1;
        if (dbus_ack) begin
            dbus_ack = 1'b0;
            d_busy   = 1'b0;
        end else if (rst_n && dbus_cyc && dbus_stb) begin
            if (!d_busy) begin
                d_busy  = 1'b1;
                d_delay = $unsigned($random(seed)) % 4;
            end
            if (d_delay == 0) begin
                assert (dbus_adr[31:11] == '0 && dbus_adr[2:0] == '0) else begin
                    $display("data access at %h falls outside the data memory", dbus_adr);
                    fail_banner();
                    $fatal(1);
                end
                assert (dbus_sel == 8'hff) else begin
                    show_mismatch($sformatf("data byte select at %h", dbus_adr),
                                  xlen_t'(8'hff), xlen_t'(dbus_sel));
                    $fatal(1);
                end
                if (dbus_we) dmem[dbus_adr[10:3]] = dbus_dat_w;
                else dbus_dat_r = dmem[dbus_adr[10:3]];
                dbus_ack = 1'b1;
            end else begin
                d_delay = d_delay - 1;
            end
        end
    end

    // every acked write must be the next store the reference model expects
    always @(negedge clk) begin
        if (rst_n && dbus_cyc && dbus_stb && dbus_we && dbus_ack) begin
            assert (exp_adr.size() > 0) else begin
                $display("store to %h comes after the last expected store", dbus_adr);
                fail_banner();
                $fatal(1);
            end
            assert (dbus_adr == exp_adr[0]) else begin
                show_mismatch($sformatf("store %0d address", stores_seen),
                              xlen_t'(exp_adr[0]), xlen_t'(dbus_adr));
                $fatal(1);
            end
            assert (dbus_dat_w == exp_dat[0]) else begin
                show_mismatch($sformatf("store %0d data", stores_seen), exp_dat[0], dbus_dat_w);
                $fatal(1);
            end
            void'(exp_adr.pop_front());
            void'(exp_dat.pop_front());
            stores_seen++;
        end
    end

    always @(posedge clk) begin
        if (UUT.u_props.violations != 0) begin
            $display("a bus protocol or reset property of the DUT was violated");
            fail_banner();
            $fatal(1);
        end
    end

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        ibus_ack    = 1'b0;
        ibus_dat_r  = '0;
        dbus_ack    = 1'b0;
        dbus_dat_r  = '0;
        i_busy      = 1'b0;
        d_busy      = 1'b0;
        i_delay     = 0;
        d_delay     = 0;
        stores_seen = 0;
        for (int r = 0; r < 32; r++) ref_regs[r] = '0;
        for (int w = 0; w < 256; w++) begin
            dmem[w]    = fill_word(w);
            ref_mem[w] = fill_word(w);
        end

        emit_addi(1, 0, 5);         // alu chain where each one reads the previous result
        emit_addi(2, 1, 7);
        emit_add(3, 2, 1);
        emit_addi(3, 3, -3);
        emit_add(4, 3, 3);
        emit_sd(4, 0, 'h200);
        emit_ld(5, 0, 'h100);       // load then an immediate use of it
        emit_add(6, 5, 4);
        emit_sd(6, 0, 'h208);
        emit_addi(7, 6, 1);         // store data written just before the store
        emit_sd(7, 0, 'h210);
        emit_addi(9, 0, 'h218);     // store base written just before the store
        emit_sd(7, 9, 0);
        emit_addi(0, 1, 99);        // x0 as destination and as source
        emit_sd(0, 0, 'h220);
        emit_add(10, 0, 0);
        emit_sd(10, 0, 'h228);
        emit_ld(0, 0, 'h108);
        emit_sd(0, 0, 'h230);
        emit_ld(11, 0, 'h200);      // reads back the first store
        emit_sd(11, 0, 'h238);
        emit_addi(12, 0, 'h400);
        emit_sd(12, 12, -8);        // negative store offset
        total_stores = exp_adr.size();

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (exp_adr.size() != 0 && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_adr.size() != 0) begin
            $display("timeout after %0d cycles with %0d of %0d stores seen",
                     cycles, stores_seen, total_stores);
            fail_banner();
            $fatal(1);
        end
        repeat (20) @(posedge clk); // trailing nops must not store anything

        if (UUT.u_props.violations == 0 && stores_seen == total_stores) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("run ended with %0d property violations", UUT.u_props.violations);
            fail_banner();
            $fatal(1);
        end
    end

endmodule

//--- seed_core_props.sv
`timescale 1ns/1ps

module seed_core_props (
    input logic            clk,
    input logic            rst_n,
    input logic            ibus_cyc,
    input logic            ibus_stb,
    input logic            ibus_we,
    input seed_pkg::addr_t ibus_adr,
    input seed_pkg::inst_t ibus_dat_w,
    input logic            ibus_ack,
    input logic            dbus_cyc,
    input logic            dbus_stb,
    input logic            dbus_we,
    input seed_pkg::addr_t dbus_adr,
    input seed_pkg::xlen_t dbus_dat_w,
    input logic            dbus_ack
);
    int violations = 0; // number of failed properties

    a_ibus_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_stb |-> ibus_cyc)
        else begin
            violations++;
            $error("ibus stb is high without cyc");
        end

    a_dbus_stb_cyc: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_stb |-> dbus_cyc)
        else begin
            violations++;
            $error("dbus stb is high without cyc");
        end

    // a request stays on the bus, unchanged, until the slave acks it
    a_ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ibus_stb && !ibus_ack) |=>
            (ibus_stb && $stable(ibus_adr) && $stable(ibus_we) && $stable(ibus_dat_w)))
        else begin
            violations++;
            $error("ibus request changed before its ack");
        end

    a_dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (dbus_stb && !dbus_ack) |=>
            (dbus_stb && $stable(dbus_adr) && $stable(dbus_we) && $stable(dbus_dat_w)))
        else begin
            violations++;
            $error("dbus request changed before its ack");
        end

    a_reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> (!ibus_cyc && !dbus_cyc))
        else begin
            violations++;
            $error("a bus cycle is open right after reset");
        end

endmodule

bind seed_core seed_core_props u_props (.*);

//--- seed_core.sv
`timescale 1ns/1ps

module seed_core (
    input  logic            clk,
    input  logic            rst_n,
    output logic            ibus_cyc,
    output logic            ibus_stb,
    output logic            ibus_we,
    output seed_pkg::addr_t ibus_adr,
    output seed_pkg::inst_t ibus_dat_w,
    output logic [3:0]      ibus_sel,
    input  seed_pkg::inst_t ibus_dat_r,
    input  logic            ibus_ack,
    output logic            dbus_cyc,
    output logic            dbus_stb,
    output logic            dbus_we,
    output seed_pkg::addr_t dbus_adr,
    output seed_pkg::xlen_t dbus_dat_w,
    output logic [7:0]      dbus_sel,
    input  seed_pkg::xlen_t dbus_dat_r,
    input  logic            dbus_ack
);
    import seed_pkg::*;

    logic      inst_valid;
    inst_t     inst;
    logic      taken;
    logic      stall;
    reg_addr_t rs1;
    reg_addr_t rs2;
    op_class_t src_class;
    xlen_t     rdata1;
    xlen_t     rdata2;
    logic      ex_valid;
    op_class_t ex_class;
    reg_addr_t ex_rd;
    xlen_t     ex_a;
    xlen_t     ex_b;
    xlen_t     ex_imm;
    logic      ex_ready;
    reg_addr_t issue_rd;
    logic      issue_load;
    logic      retire;
    logic      wb_en;
    reg_addr_t wb_rd;
    xlen_t     wb_data;

    // fetch keeps its word until decode hands it on to execute
    seed_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .ibus_cyc   (ibus_cyc),
        .ibus_stb   (ibus_stb),
        .ibus_we    (ibus_we),
        .ibus_adr   (ibus_adr),
        .ibus_dat_w (ibus_dat_w),
        .ibus_sel   (ibus_sel),
        .ibus_dat_r (ibus_dat_r),
        .ibus_ack   (ibus_ack),
        .stall      (!taken),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    ()
    );

    seed_decode u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stall      (stall),
        .ex_ready   (ex_ready),
        .taken      (taken),
        .rs1        (rs1),
        .rs2        (rs2),
        .src_class  (src_class),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .ex_valid   (ex_valid),
        .ex_class   (ex_class),
        .ex_rd      (ex_rd),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_imm     (ex_imm)
    );

    seed_regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wen    (wb_en),
        .waddr  (wb_rd),
        .wdata  (wb_data)
    );

    seed_hazard u_hazard (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .src_valid  (src_class != op_nop), // nops never wait
        .issue_rd   (issue_rd),
        .issue_load (issue_load),
        .issue      (taken),
        .retire     (retire),
        .wb_rd      (wb_rd),
        .wb_en      (wb_en),
        .stall      (stall)
    );

    seed_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .ex_class   (ex_class),
        .ex_rd      (ex_rd),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_imm     (ex_imm),
        .ex_ready   (ex_ready),
        .issue_rd   (issue_rd),
        .issue_load (issue_load),
        .retire     (retire),
        .dbus_cyc   (dbus_cyc),
        .dbus_stb   (dbus_stb),
        .dbus_we    (dbus_we),
        .dbus_adr   (dbus_adr),
        .dbus_dat_w (dbus_dat_w),
        .dbus_sel   (dbus_sel),
        .dbus_dat_r (dbus_dat_r),
        .dbus_ack   (dbus_ack),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

//--- seed_execute.sv
`timescale 1ns/1ps

module seed_execute (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ex_valid,
    input  seed_pkg::op_class_t ex_class,
    input  seed_pkg::reg_addr_t ex_rd,
    input  seed_pkg::xlen_t     ex_a,
    input  seed_pkg::xlen_t     ex_b,
    input  seed_pkg::xlen_t     ex_imm,
    output logic                ex_ready,
    output seed_pkg::reg_addr_t issue_rd,
    output logic                issue_load,
    output logic                retire,
    output logic                dbus_cyc,
    output logic                dbus_stb,
    output logic                dbus_we,
    output seed_pkg::addr_t     dbus_adr,
    output seed_pkg::xlen_t     dbus_dat_w,
    output logic [7:0]          dbus_sel,
    input  seed_pkg::xlen_t     dbus_dat_r,
    input  logic                dbus_ack,
    output logic                wb_en,
    output seed_pkg::reg_addr_t wb_rd,
    output seed_pkg::xlen_t     wb_data
);
    import seed_pkg::*;

    ex_state_t state;
    logic      bus_req;
    logic      is_mem;
    logic      alu_go;  // alu or nop finishes in its first execute cycle
    logic      mem_go;  // a load or store starts its bus access
    xlen_t     eff_addr;
    xlen_t     alu_sum;

    assign is_mem   = (ex_class == op_load) || (ex_class == op_store);
    assign alu_go   = (state == ex_idle) && ex_valid && !is_mem;
    assign mem_go   = (state == ex_idle) && ex_valid && is_mem;
    assign eff_addr = ex_a + ex_imm;
    assign alu_sum  = ex_a + ex_b;

    assign ex_ready   = (state == ex_done) || ((state == ex_idle) && !mem_go);
    assign retire     = (state == ex_done) || alu_go;
    assign issue_rd   = ex_valid ? ex_rd : '0;
    assign issue_load = ex_valid && (ex_class == op_load);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ex_idle;
            bus_req <= 1'b0;
            dbus_we <= 1'b0;
            wb_en   <= 1'b0;
        end else begin
            wb_en <= 1'b0;
            case (state)
                ex_idle: begin
                    if (mem_go) begin
                        bus_req <= 1'b1;
                        dbus_we <= (ex_class == op_store);
                        state   <= ex_bus;
                    end else if (alu_go) begin
                        wb_en <= (ex_class == op_alu) && (ex_rd != '0);
                    end
                end
                ex_bus: begin
                    if (dbus_ack) begin // cyc and stb fall in the next cycle
                        bus_req <= 1'b0;
                        dbus_we <= 1'b0;
                        wb_en   <= (ex_class == op_load) && (ex_rd != '0);
                        state   <= ex_done;
                    end
                end
                default: state <= ex_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mem_go) begin
            dbus_adr   <= eff_addr[31:0];
            dbus_dat_w <= ex_b; // store data for sd
        end
        if (alu_go) begin
            wb_rd   <= ex_rd;
            wb_data <= alu_sum;
        end else if (state == ex_bus && dbus_ack) begin
            wb_rd   <= ex_rd;
            wb_data <= dbus_dat_r;
        end
    end

    assign dbus_cyc = bus_req;
    assign dbus_stb = bus_req;
    assign dbus_sel = 8'hff; // always full doubleword accesses

endmodule

//--- seed_hazard.sv
`timescale 1ns/1ps

module seed_hazard (
    input  logic                clk,
    input  logic                rst_n,
    input  seed_pkg::reg_addr_t rs1,
    input  seed_pkg::reg_addr_t rs2,
    input  logic                src_valid,
    input  seed_pkg::reg_addr_t issue_rd,
    input  logic                issue_load,
    input  logic                issue,
    input  logic                retire,
    input  seed_pkg::reg_addr_t wb_rd,
    input  logic                wb_en,
    output logic                stall
);
    import seed_pkg::*;

    logic      ex_pend; // execute holds an instruction that has not retired
    logic      wb_pend; // an alu result sits in writeback, not yet in the register file
    reg_addr_t wb_q;
    logic      ex_live;

    function automatic logic src_busy(input reg_addr_t src);
        logic hit_ex;
        logic hit_wb;
        hit_ex = ex_live && (src == issue_rd);
        hit_wb = wb_pend && (src == wb_q);
        return (src != '0) && (hit_ex || hit_wb);
    endfunction

    // issue_rd already reads x0 for stores and nops
    assign ex_live = ex_pend && (issue_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_pend <= 1'b0;
            wb_pend <= 1'b0;
        end else begin
            if (issue) begin
                ex_pend <= 1'b1; // a new instruction enters execute at this edge
            end else if (retire) begin
                ex_pend <= 1'b0; // loads only get here after their ack
            end
            // a load retires in its own writeback cycle, so only alu results move here
            if (retire && !issue_load && issue_rd != '0) begin
                wb_pend <= 1'b1;
            end else if (wb_en && wb_rd == wb_q) begin
                wb_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire && !issue_load && issue_rd != '0) begin
            wb_q <= issue_rd;
        end
    end

    assign stall = src_valid && (src_busy(rs1) || src_busy(rs2));

endmodule

//--- seed_decode.sv
`timescale 1ns/1ps
`include "seed_defs.svh"

module seed_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_valid,
    input  seed_pkg::inst_t     inst,
    input  logic                stall,
    input  logic                ex_ready,
    output logic                taken,
    output seed_pkg::reg_addr_t rs1,
    output seed_pkg::reg_addr_t rs2,
    output seed_pkg::op_class_t src_class,
    input  seed_pkg::xlen_t     rdata1,
    input  seed_pkg::xlen_t     rdata2,
    output logic                ex_valid,
    output seed_pkg::op_class_t ex_class,
    output seed_pkg::reg_addr_t ex_rd,
    output seed_pkg::xlen_t     ex_a,
    output seed_pkg::xlen_t     ex_b,
    output seed_pkg::xlen_t     ex_imm
);
    import seed_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t      imm_i;
    xlen_t      imm_s;
    logic       uses_rs2;
    logic       writes_rd;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{52{inst[31]}}, inst[31:20]};
    assign imm_s  = {{52{inst[31]}}, inst[31:25], inst[11:7]};

    always_comb begin
        src_class = op_nop; // anything unrecognized just flows through as a nop
        if (inst_valid) begin
            case (opcode)
                `SEED_OP_IMM: begin
                    if (funct3 == `SEED_F3_ADD) src_class = op_alu;
                end
                `SEED_OP_REG: begin
                    if (funct3 == `SEED_F3_ADD && funct7 == 7'd0) src_class = op_alu;
                end
                `SEED_OP_LOAD: begin
                    if (funct3 == `SEED_F3_DWORD) src_class = op_load;
                end
                `SEED_OP_STORE: begin
                    if (funct3 == `SEED_F3_DWORD) src_class = op_store;
                end
                default: src_class = op_nop;
            endcase
        end
    end

    assign uses_rs2  = (src_class == op_store) ||
                       (src_class == op_alu && opcode == `SEED_OP_REG);
    assign writes_rd = (src_class == op_alu) || (src_class == op_load);

    // unused sources read as x0 so the hazard unit ignores them
    assign rs1   = (src_class != op_nop) ? inst[19:15] : '0;
    assign rs2   = uses_rs2 ? inst[24:20] : '0;
    assign taken = inst_valid && !stall && ex_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_class <= op_nop;
        end else if (ex_ready) begin
            ex_valid <= taken;
            ex_class <= taken ? src_class : op_nop;
        end
    end

    always_ff @(posedge clk) begin
        if (taken) begin
            ex_rd  <= writes_rd ? inst[11:7] : '0; // stores carry no destination
            ex_a   <= rdata1;
            ex_b   <= uses_rs2 ? rdata2 : imm_i;   // addi folds its immediate in here
            ex_imm <= (src_class == op_store) ? imm_s : imm_i;
        end
    end

endmodule

//--- seed_fetch.sv
`timescale 1ns/1ps
`include "seed_defs.svh"

module seed_fetch (
    input  logic            clk,
    input  logic            rst_n,
    output logic            ibus_cyc,
    output logic            ibus_stb,
    output logic            ibus_we,
    output seed_pkg::addr_t ibus_adr,
    output seed_pkg::inst_t ibus_dat_w,
    output logic [3:0]      ibus_sel,
    input  seed_pkg::inst_t ibus_dat_r,
    input  logic            ibus_ack,
    input  logic            stall,
    output logic            inst_valid,
    output seed_pkg::inst_t inst,
    output seed_pkg::addr_t inst_pc
);
    import seed_pkg::*;

    logic  req;     // a read is outstanding on ibus
    addr_t pc;      // address of the next instruction to fetch
    logic  release_inst;

    assign release_inst = inst_valid && !stall; // decode takes the held word

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req        <= 1'b0;
            inst_valid <= 1'b0;
            pc         <= `SEED_RESET_PC;
        end else begin
            if (release_inst) begin
                inst_valid <= 1'b0;
            end
            if (req) begin
                if (ibus_ack) begin // drop the request the cycle after ack
                    req        <= 1'b0;
                    inst_valid <= 1'b1;
                    pc         <= pc + 32'd4;
                end
            end else if (!inst_valid || release_inst) begin
                req <= 1'b1; // slot is free or frees up at this edge
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && ibus_ack) begin
            inst    <= ibus_dat_r;
            inst_pc <= pc;
        end
    end

    assign ibus_cyc   = req;
    assign ibus_stb   = req;
    assign ibus_we    = 1'b0; // read-only master
    assign ibus_adr   = pc;   // pc only moves on ack, so adr stays stable
    assign ibus_dat_w = '0;
    assign ibus_sel   = 4'hf;

endmodule

//--- seed_regfile.sv
`timescale 1ns/1ps
`include "seed_defs.svh"

module seed_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  seed_pkg::reg_addr_t raddr1,
    input  seed_pkg::reg_addr_t raddr2,
    output seed_pkg::xlen_t     rdata1,
    output seed_pkg::xlen_t     rdata2,
    input  logic                wen,
    input  seed_pkg::reg_addr_t waddr,
    input  seed_pkg::xlen_t     wdata
);
    import seed_pkg::*;

    xlen_t regs [`SEED_NUM_REGS];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SEED_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    // no write-through, a value becomes visible the cycle after its write
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- seed_pkg.sv
package seed_pkg;

    typedef logic [63:0] xlen_t;     // one data word
    typedef logic [31:0] addr_t;     // bus byte address
    typedef logic [31:0] inst_t;     // raw instruction word
    typedef logic [4:0]  reg_addr_t; // register index

    // what an instruction does once it leaves decode
    typedef logic [1:0] op_class_t;

    localparam op_class_t op_nop   = 2'd0;
    localparam op_class_t op_alu   = 2'd1;
    localparam op_class_t op_load  = 2'd2;
    localparam op_class_t op_store = 2'd3;

    // execute-stage sequencing, ex_bus waits for the data bus ack
    typedef enum logic [1:0] {
        ex_idle,
        ex_bus,
        ex_done
    } ex_state_t;

endpackage

//--- seed_defs.svh
`ifndef SEED_DEFS_SVH
`define SEED_DEFS_SVH

// first fetch address after reset
`define SEED_RESET_PC 32'h8000_0000

// major opcodes of the four supported instructions
`define SEED_OP_IMM   7'b0010011 // addi
`define SEED_OP_REG   7'b0110011 // add
`define SEED_OP_LOAD  7'b0000011 // ld
`define SEED_OP_STORE 7'b0100011 // sd

// funct3 values that select the supported variants
`define SEED_F3_ADD   3'b000
`define SEED_F3_DWORD 3'b011

// integer register file size
`define SEED_NUM_REGS 32

`endif
